// File: all.f
source/line_cam_pkg.sv
source/pixel_capture.sv
source/frame_pingpong.sv
source/spi_frame_reader.sv
source/line_cam_top.sv
verification/line_cam_tb.sv

// File: run.sh
#!/bin/sh
# Build the line camera testbench with Verilator and run it.
# The run passes only if the pass message shows up in the simulation output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module line_cam_tb \
    -f all.f -o line_cam_sim &&
./obj_dir/line_cam_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: source/frame_pingpong.sv
// Two byte-wide banks of FRAME_WIDTH*FRAME_HEIGHT/8; reads come from the bank not written
// Write address only restarts on frame_done, so an aborted frame shifts the next one
`timescale 1ns/1ps

module frame_pingpong #(
    parameter int  FRAME_WIDTH  = line_cam_pkg::DEFAULT_FRAME_WIDTH,
    parameter int  FRAME_HEIGHT = line_cam_pkg::DEFAULT_FRAME_HEIGHT,
    localparam int BYTES        = FRAME_WIDTH * FRAME_HEIGHT / line_cam_pkg::PIXELS_PER_BYTE,
    localparam int AW           = (BYTES > 1) ? $clog2(BYTES) : 1
) (
    input  logic                clk,
    input  logic                nreset,
    input  logic                pix_valid,
    input  logic                pix_bit,
    input  logic                frame_done,
    input  logic [AW-1:0]       rd_addr,
    output line_cam_pkg::luma_t rd_data,
    output logic                frame_ready
);

    localparam int PPB   = line_cam_pkg::PIXELS_PER_BYTE;
    localparam int BW    = $clog2(PPB);
    localparam logic [BW-1:0] BIT_LAST = BW'(PPB - 1);

    // ----------------------------------------------------------
    // Bit packing, first pixel ends up in the MSB
    // ----------------------------------------------------------
    line_cam_pkg::luma_t packer;
    logic [BW-1:0]       bit_cnt;

    always_ff @(posedge clk) begin
        if (pix_valid) packer <= {packer[PPB-2:0], pix_bit};
    end

    // ----------------------------------------------------------
    // Write pointer and bank control
    // ----------------------------------------------------------
    logic          bank_sel;    // Bank being written; the other is read
    logic          wr_en;       // Full byte waiting in packer
    logic          wr_bank;     // Bank latched with the byte
    logic [AW-1:0] wr_ptr;      // Address latched with the byte
    logic [AW-1:0] next_addr;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            bit_cnt     <= '0;
            bank_sel    <= 1'b0;
            wr_en       <= 1'b0;
            wr_bank     <= 1'b0;
            wr_ptr      <= '0;
            next_addr   <= '0;
            frame_ready <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (pix_valid) begin
                bit_cnt <= (bit_cnt == BIT_LAST) ? '0 : bit_cnt + 1'b1;
                if (bit_cnt == BIT_LAST) begin
                    wr_en     <= 1'b1;
                    wr_bank   <= bank_sel;  // Swap below must not redirect the last byte
                    wr_ptr    <= next_addr;
                    next_addr <= next_addr + 1'b1;
                end
            end
            if (frame_done) begin
                next_addr   <= '0;
                bank_sel    <= ~bank_sel;
                frame_ready <= 1'b1;        // Sticks once a frame exists
            end
        end
    end

    // ----------------------------------------------------------
    // Frame banks
    // ----------------------------------------------------------
    line_cam_pkg::luma_t bank0 [BYTES];
    line_cam_pkg::luma_t bank1 [BYTES];

    always_ff @(posedge clk) begin
        if (wr_en && !wr_bank) bank0[wr_ptr] <= packer;
        if (wr_en && wr_bank)  bank1[wr_ptr] <= packer;
        rd_data <= bank_sel ? bank0[rd_addr] : bank1[rd_addr];  // One clock read
    end

endmodule

// File: source/line_cam_pkg.sv
// Shared defaults for the line camera. FRAME_WIDTH must be a multiple of PIXELS_PER_BYTE
// Camera bytes alternate luma and chroma, starting with luma
package line_cam_pkg;

    // ----------------------------------------------------------
    // Frame geometry and threshold defaults
    // ----------------------------------------------------------
    parameter int DEFAULT_FRAME_WIDTH  = 320;   // Pixels per line
    parameter int DEFAULT_FRAME_HEIGHT = 240;   // Lines per frame

    // Pixel is 1 only when luma is strictly above this
    parameter logic [7:0] DEFAULT_THRESHOLD = 8'd128;

    // ----------------------------------------------------------
    // Fixed structure constants
    // ----------------------------------------------------------
    parameter int SYNC_STAGES     = 2;          // Input synchronizer depth, at least 2
    parameter int PIXELS_PER_BYTE = 8;          // One bit per pixel in the store

    // Camera data byte
    typedef logic [7:0] luma_t;

endpackage

// File: source/line_cam_top.sv
// Single clock design; camera and SPI pins are oversampled by clk
// FRAME_WIDTH must be a multiple of 8
`timescale 1ns/1ps

module line_cam_top #(
    parameter int                  FRAME_WIDTH  = line_cam_pkg::DEFAULT_FRAME_WIDTH,
    parameter int                  FRAME_HEIGHT = line_cam_pkg::DEFAULT_FRAME_HEIGHT,
    parameter line_cam_pkg::luma_t THRESHOLD    = line_cam_pkg::DEFAULT_THRESHOLD
) (
    input  logic                clk,
    input  logic                nreset,
    input  logic                cam_pclk,
    input  logic                cam_vsync,
    input  logic                cam_href,
    input  line_cam_pkg::luma_t cam_data,
    input  logic                spi_sck,
    input  logic                spi_ncs,
    output logic                spi_miso
);

    localparam int BYTES = FRAME_WIDTH * FRAME_HEIGHT / line_cam_pkg::PIXELS_PER_BYTE;
    localparam int AW    = (BYTES > 1) ? $clog2(BYTES) : 1;

    logic                pix_valid;
    logic                pix_bit;
    logic                frame_done;
    logic                frame_ready;
    logic [AW-1:0]       rd_addr;
    line_cam_pkg::luma_t rd_data;

    // Camera bytes to thresholded pixels
    pixel_capture #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT),
        .THRESHOLD    (THRESHOLD)
    ) u_capture (
        .clk        (clk),
        .nreset     (nreset),
        .cam_pclk   (cam_pclk),
        .cam_vsync  (cam_vsync),
        .cam_href   (cam_href),
        .cam_data   (cam_data),
        .pix_valid  (pix_valid),
        .pix_bit    (pix_bit),
        .frame_done (frame_done)
    );

    // Packed ping-pong store
    frame_pingpong #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) u_store (
        .clk         (clk),
        .nreset      (nreset),
        .pix_valid   (pix_valid),
        .pix_bit     (pix_bit),
        .frame_done  (frame_done),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .frame_ready (frame_ready)
    );

    // SPI readout of the last complete frame
    spi_frame_reader #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) u_reader (
        .clk         (clk),
        .nreset      (nreset),
        .spi_sck     (spi_sck),
        .spi_ncs     (spi_ncs),
        .rd_data     (rd_data),
        .frame_ready (frame_ready),
        .rd_addr     (rd_addr),
        .spi_miso    (spi_miso)
    );

endmodule

// File: source/pixel_capture.sv
// Camera pins are sampled as slow levels on clk; pclk must stay high and low 4+ clocks
// Bytes outside an armed frame (before vsync or after the last line) are dropped
`timescale 1ns/1ps

module pixel_capture #(
    parameter int                  FRAME_WIDTH  = line_cam_pkg::DEFAULT_FRAME_WIDTH,
    parameter int                  FRAME_HEIGHT = line_cam_pkg::DEFAULT_FRAME_HEIGHT,
    parameter line_cam_pkg::luma_t THRESHOLD    = line_cam_pkg::DEFAULT_THRESHOLD
) (
    input  logic                clk,
    input  logic                nreset,
    input  logic                cam_pclk,
    input  logic                cam_vsync,
    input  logic                cam_href,
    input  line_cam_pkg::luma_t cam_data,
    output logic                pix_valid,
    output logic                pix_bit,
    output logic                frame_done
);

    localparam int SYNC = line_cam_pkg::SYNC_STAGES;
    localparam int PW   = (FRAME_WIDTH > 1) ? $clog2(FRAME_WIDTH) : 1;
    localparam int LW   = (FRAME_HEIGHT > 1) ? $clog2(FRAME_HEIGHT) : 1;
    localparam logic [PW-1:0] PIX_LAST  = PW'(FRAME_WIDTH - 1);
    localparam logic [LW-1:0] LINE_LAST = LW'(FRAME_HEIGHT - 1);

    // ----------------------------------------------------------
    // Input synchronizers and edge detect
    // ----------------------------------------------------------
    logic [SYNC-1:0]     pclk_sync, vsync_sync, href_sync;
    logic                pclk_last, vsync_last;
    line_cam_pkg::luma_t data_sync [SYNC];

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            pclk_sync  <= '0;
            vsync_sync <= '0;
            href_sync  <= '0;
            pclk_last  <= 1'b0;
            vsync_last <= 1'b0;
        end else begin
            pclk_sync  <= {pclk_sync[SYNC-2:0], cam_pclk};
            vsync_sync <= {vsync_sync[SYNC-2:0], cam_vsync};
            href_sync  <= {href_sync[SYNC-2:0], cam_href};
            pclk_last  <= pclk_sync[SYNC-1];
            vsync_last <= vsync_sync[SYNC-1];
        end
    end

    // Data follows the same path as the strobes
    always_ff @(posedge clk) begin
        data_sync[0] <= cam_data;
        for (int i = 1; i < SYNC; i++) begin
            data_sync[i] <= data_sync[i-1];
        end
    end

    wire pclk_rise  = pclk_sync[SYNC-1] & ~pclk_last;
    wire vsync_rise = vsync_sync[SYNC-1] & ~vsync_last;

    // ----------------------------------------------------------
    // Byte take, one stage ahead of the pixel decision
    // ----------------------------------------------------------
    logic                take;      // Byte inside an armed line
    logic                armed;     // Between vsync and last pixel
    line_cam_pkg::luma_t byte_q;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            take <= 1'b0;
        end else begin
            take <= pclk_rise & href_sync[SYNC-1] & armed;
        end
    end

    always_ff @(posedge clk) begin
        if (pclk_rise) byte_q <= data_sync[SYNC-1];
        pix_bit <= (byte_q > THRESHOLD);   // Strictly greater
    end

    // ----------------------------------------------------------
    // Luma/chroma phase, pixel and line counters
    // ----------------------------------------------------------
    logic          chroma;      // 0 = next byte is luma
    logic [PW-1:0] pix_cnt;
    logic [LW-1:0] line_cnt;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            armed      <= 1'b0;
            chroma     <= 1'b0;
            pix_cnt    <= '0;
            line_cnt   <= '0;
            pix_valid  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            pix_valid  <= 1'b0;
            frame_done <= 1'b0;
            if (vsync_rise) begin               // New frame wins over a byte in flight
                armed    <= 1'b1;
                chroma   <= 1'b0;
                pix_cnt  <= '0;
                line_cnt <= '0;
            end else if (take) begin
                if (!chroma) begin
                    pix_valid <= 1'b1;
                    chroma    <= 1'b1;
                    // Last pixel of the last line closes the frame
                    if (pix_cnt == PIX_LAST && line_cnt == LINE_LAST) begin
                        frame_done <= 1'b1;
                        armed      <= 1'b0;
                    end
                end else begin
                    chroma <= 1'b0;             // Pair complete
                    if (pix_cnt == PIX_LAST) begin
                        pix_cnt  <= '0;
                        line_cnt <= line_cnt + 1'b1;
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: source/spi_frame_reader.sv
// SPI mode 0 slave, read only; wait 8+ clocks after ncs falls, sck half period 8+ clocks
// Reads wrap to byte 0 after the last byte of the frame
`timescale 1ns/1ps

module spi_frame_reader #(
    parameter int  FRAME_WIDTH  = line_cam_pkg::DEFAULT_FRAME_WIDTH,
    parameter int  FRAME_HEIGHT = line_cam_pkg::DEFAULT_FRAME_HEIGHT,
    localparam int BYTES        = FRAME_WIDTH * FRAME_HEIGHT / line_cam_pkg::PIXELS_PER_BYTE,
    localparam int AW           = (BYTES > 1) ? $clog2(BYTES) : 1
) (
    input  logic                clk,
    input  logic                nreset,
    input  logic                spi_sck,
    input  logic                spi_ncs,
    input  line_cam_pkg::luma_t rd_data,
    input  logic                frame_ready,
    output logic [AW-1:0]       rd_addr,
    output logic                spi_miso
);

    localparam int SYNC  = line_cam_pkg::SYNC_STAGES;
    localparam logic [AW-1:0] ADDR_LAST = AW'(BYTES - 1);

    // ----------------------------------------------------------
    // SPI pin synchronizers
    // ----------------------------------------------------------
    logic [SYNC-1:0] sck_sync, ncs_sync;
    logic            sck_last, ncs_last;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            sck_sync <= '0;
            ncs_sync <= '1;             // Deselected
            sck_last <= 1'b0;
            ncs_last <= 1'b1;
        end else begin
            sck_sync <= {sck_sync[SYNC-2:0], spi_sck};
            ncs_sync <= {ncs_sync[SYNC-2:0], spi_ncs};
            sck_last <= sck_sync[SYNC-1];
            ncs_last <= ncs_sync[SYNC-1];
        end
    end

    wire sck_fall = ~sck_sync[SYNC-1] & sck_last;
    wire ncs_fall = ~ncs_sync[SYNC-1] & ncs_last;
    wire ncs_rise = ncs_sync[SYNC-1] & ~ncs_last;

    // Wrapping byte address
    wire [AW-1:0] addr_next = (rd_addr == ADDR_LAST) ? '0 : rd_addr + 1'b1;

    // ----------------------------------------------------------
    // Transfer control and shifter
    // ----------------------------------------------------------
    logic       xfer;           // Frame was ready at select
    logic [1:0] prime;          // Waits out the read latency for byte 0
    logic [2:0] bit_cnt;        // sck falls within the byte
    logic [7:0] shifter;

    always_ff @(posedge clk or negedge nreset) begin
        if (!nreset) begin
            xfer    <= 1'b0;
            prime   <= '0;
            bit_cnt <= '0;
            shifter <= '0;
            rd_addr <= '0;
        end else begin
            prime <= {prime[0], 1'b0};
            if (ncs_rise) begin
                xfer    <= 1'b0;
                prime   <= '0;
                shifter <= '0;
            end else if (ncs_fall) begin
                xfer    <= frame_ready; // No frame, shifter stays 0
                prime   <= {1'b0, frame_ready};
                bit_cnt <= '0;
                shifter <= '0;
                rd_addr <= '0;
            end else if (prime[1]) begin
                shifter <= rd_data;     // Byte 0
                rd_addr <= addr_next;   // Prefetch byte 1
            end else if (xfer && sck_fall) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7) begin
                    shifter <= rd_data; // Prefetched byte
                    rd_addr <= addr_next;
                end else begin
                    shifter <= {shifter[6:0], 1'b0};
                end
            end
        end
    end

    // Line is quiet while deselected
    assign spi_miso = ~spi_ncs & shifter[7];

endmodule

// File: verification/line_cam_tb.sv
// Drives line_cam_top with a 16x4 frame (8 bytes). Camera and SPI pins change on falling clk
// Expected bytes come from a packing model, where a pixel is 1 only when its luma is above 128
`timescale 1ns/1ps

module line_cam_tb;

    localparam int         WIDTH          = 16;
    localparam int         HEIGHT         = 4;
    localparam logic [7:0] THRESHOLD      = 8'd128;
    localparam int         PIXELS         = WIDTH * HEIGHT;
    localparam int         BYTES          = PIXELS / 8;
    localparam int         PCLK_PHASE     = 5;      // Clocks per pclk level
    localparam int         HALF_SCK       = 10;     // Clocks per sck level
    localparam int         LEAD           = 12;     // ncs fall to first sck rise
    localparam int         TIMEOUT_CLOCKS = 200000;

    // Frame kinds
    localparam int KIND_NONE       = 0;     // No capture, read only
    localparam int KIND_RANDOM     = 1;
    localparam int KIND_EQUAL      = 2;     // Every luma exactly at threshold
    localparam int KIND_CHROMA_INV = 3;     // Chroma opposes the luma result
    localparam int KIND_PARTIAL    = 4;     // Last line missing

    // ----------------------------------------------------------
    // Frame table, applied in order
    // ----------------------------------------------------------
    localparam int ROWS = 7;
    int row_kind  [ROWS] = '{KIND_NONE, KIND_RANDOM, KIND_CHROMA_INV, KIND_EQUAL,
                             KIND_RANDOM, KIND_RANDOM, KIND_PARTIAL};
    bit row_read  [ROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
    int row_bytes [ROWS] = '{8, 8, 8, 8, 0, 12, 8};   // 12 shows the address wrap

    logic                clk;
    logic                nreset;
    logic                cam_pclk;
    logic                cam_vsync;
    logic                cam_href;
    line_cam_pkg::luma_t cam_data;
    logic                spi_sck;
    logic                spi_ncs;
    logic                spi_miso;

    logic [31:0]         rng_state;
    int                  errors;
    int                  checks;
    line_cam_pkg::luma_t luma [PIXELS];     // Frame being sent
    logic [7:0]          expected [BYTES];  // Last complete frame, packed

    line_cam_top #(
        .FRAME_WIDTH  (WIDTH),
        .FRAME_HEIGHT (HEIGHT),
        .THRESHOLD    (THRESHOLD)
    ) uut (
        .clk       (clk),
        .nreset    (nreset),
        .cam_pclk  (cam_pclk),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_data  (cam_data),
        .spi_sck   (spi_sck),
        .spi_ncs   (spi_ncs),
        .spi_miso  (spi_miso)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                   // 10 ns period

    // Watchdog over the whole run
    initial begin
        for (int t = 0; t < TIMEOUT_CLOCKS; t++) @(posedge clk);
        $display("Simulation timed out before the test sequence finished");
        $display("ERRORS FOUND");
        $finish;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    task automatic wait_clocks(input int n);
        for (int i = 0; i < n; i++) @(negedge clk);
    endtask

    task automatic check_equal(input logic [7:0] got, input logic [7:0] want,
                               input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED at %0t: %s, got %02h expected %02h", $time, what, got, want);
        end
    endtask

    // One camera byte, data set a full phase before the pclk rise
    task automatic send_byte(input logic [7:0] data, input logic href);
        cam_data = data;
        cam_href = href;
        cam_pclk = 1'b0;
        wait_clocks(PCLK_PHASE);
        cam_pclk = 1'b1;
        wait_clocks(PCLK_PHASE);
    endtask

    task automatic fill_luma(input int kind);
        for (int p = 0; p < PIXELS; p++) begin
            if (kind == KIND_EQUAL) luma[p] = THRESHOLD;
            else luma[p] = next_random();
        end
        if (kind != KIND_EQUAL) begin
            luma[0] = 8'd128;               // Edge of the compare
            luma[1] = 8'd129;
            luma[PIXELS / 2] = 8'hff;       // MSB of byte 4, left loaded after a 12 byte read
        end
    endtask

    // Raster order, first pixel of each group of 8 in the MSB
    task automatic pack_expected();
        logic [7:0] e;
        for (int b = 0; b < BYTES; b++) begin
            e = '0;
            for (int j = 0; j < 8; j++) e[7 - j] = (luma[b * 8 + j] > THRESHOLD);
            expected[b] = e;
        end
    endtask

    task automatic send_frame(input int kind);
        int         lines;
        int         p;
        logic [7:0] chroma;
        fill_luma(kind);
        lines = (kind == KIND_PARTIAL) ? HEIGHT - 1 : HEIGHT;
        for (int i = 0; i < 3; i++) send_byte(next_random(), 1'b1);   // Stray, not armed
        cam_href  = 1'b0;
        cam_vsync = 1'b1;
        wait_clocks(6);
        cam_vsync = 1'b0;
        wait_clocks(6);
        for (int l = 0; l < lines; l++) begin
            for (int c = 0; c < WIDTH; c++) begin
                p = l * WIDTH + c;
                if (kind == KIND_CHROMA_INV) chroma = (luma[p] > THRESHOLD) ? 8'h00 : 8'hff;
                else chroma = next_random();
                send_byte(luma[p], 1'b1);
                send_byte(chroma, 1'b1);
            end
            send_byte(next_random(), 1'b0);     // Line blanking
            send_byte(next_random(), 1'b0);
        end
        if (kind != KIND_PARTIAL) pack_expected();
    endtask

    // Mode 0 master, miso taken just before each sck rise
    task automatic read_and_check(input int row, input int n);
        logic [7:0] got;
        logic       seen;
        spi_ncs = 1'b0;
        wait_clocks(LEAD);
        for (int i = 0; i < n; i++) begin
            got = '0;
            for (int k = 0; k < 8; k++) begin
                got     = {got[6:0], spi_miso};
                spi_sck = 1'b1;
                wait_clocks(HALF_SCK);
                spi_sck = 1'b0;
                wait_clocks(HALF_SCK);
            end
            check_equal(got, expected[i % BYTES], $sformatf("row %0d byte %0d", row, i));
        end
        spi_ncs = 1'b1;
        seen    = 1'b0;
        for (int c = 0; c < HALF_SCK; c++) begin
            @(negedge clk);
            seen = seen | spi_miso;         // Shifter still holds the next byte at first
        end
        check_equal({7'd0, seen}, 8'd0, $sformatf("row %0d miso while deselected", row));
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        nreset    = 1'b0;
        cam_pclk  = 1'b0;
        cam_vsync = 1'b0;
        cam_href  = 1'b0;
        cam_data  = '0;
        spi_sck   = 1'b0;
        spi_ncs   = 1'b1;
        rng_state = 32'h8014_2cbe;
        errors    = 0;
        checks    = 0;
        for (int b = 0; b < BYTES; b++) expected[b] = '0;   // No frame yet reads as zeros
        wait_clocks(4);
        nreset = 1'b1;
        wait_clocks(4);
        for (int r = 0; r < ROWS; r++) begin
            if (row_kind[r] != KIND_NONE) send_frame(row_kind[r]);
            if (row_read[r]) read_and_check(r, row_bytes[r]);
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) $display("NO ERRORS");
        else $display("ERRORS FOUND");
        $finish;
    end

endmodule
